/* alarmConsole.f */
consolePkg.sv
keyBus.sv
ps2Receiver.sv
vgaTiming.sv
vgaRenderer.sv
alarmTone.sv
alarmConsole.sv
alarmConsole_tb.sv

/* alarmConsole_tb.sv */
// Alarm console testbench
`timescale 1ns/1ps
`default_nettype none

module alarmConsole_tb import consolePkg::*; ();

	localparam int frameClocks = hTotal * vTotal * pixelDivide; // Clocks per VGA frame
	localparam int cycleLimit = frameClocks + 64 * hTotal * pixelDivide; // Frame 1 bands plus margin

	logic clk, reset, writeStrobe, readRequest, alarm, ps2c, ps2d;
	byteT portId, outPort, keyOut;
	rgbT rgb;
	logic hs, vs, speaker;

	byteT modelNow = '0; // Expected keyNow
	byteT modelPrev = '0; // Expected keyPrev
	logic breakSeen = 1'b0; // Last good frame was a break prefix
	rgbT modelFg = resetColor; // Expected foreground
	int relClk = 0; // Clock edges since reset release
	int cycleCount = 0;
	int checkCount = 0;
	int errorCount = 0;

	alarmConsole dut_i (
		.clk(clk), .reset(reset), .portId(portId), .writeStrobe(writeStrobe),
		.outPort(outPort), .readRequest(readRequest), .keyOut(keyOut), .alarm(alarm),
		.ps2c(ps2c), .ps2d(ps2d), .rgb(rgb), .hs(hs), .vs(vs), .speaker(speaker)
	);

	initial begin
		clk = 1'b0;
		forever #50 clk = !clk; // 100 ns period
	end

	always @(posedge clk) begin
		cycleCount <= cycleCount + 1;
		relClk <= reset ? 0 : relClk + 1;
		if (cycleCount >= cycleLimit) begin
			$display("timeout: run did not finish within %0d cycles", cycleLimit);
			$display("TEST RESULT: FAIL");
			$finish;
		end
	end

	task automatic checkValue(input logic [31:0] got, input logic [31:0] exp, input string what);
		checkCount++;
		assert (got === exp) else begin
			errorCount++;
			$display("error %0t: %s is %h, expected %h", $time, what, got, exp);
		end
	endtask

	// One PS/2 frame, device clocked, half period of 8 clocks
	task automatic sendFrame(input byteT code, input logic badParity, input logic badStop);
		logic [10:0] frame;
		int b;
		frame = {~badStop, ~(^code) ^ badParity, code, 1'b0}; // Stop, odd parity, data, start
		for (b = 0; b < 11; b++) begin
			@(posedge clk);
			ps2d <= frame[b]; // Data settles while ps2c high
			repeat (8) @(posedge clk);
			ps2c <= 1'b0;
			repeat (8) @(posedge clk);
			ps2c <= 1'b1;
		end
		@(posedge clk);
		ps2d <= 1'b1;
		repeat (20) @(posedge clk); // Idle bus before the next frame
		if (!badParity && !badStop) begin
			if (code == breakPrefix)
				breakSeen = 1'b1;
			else if (breakSeen)
				breakSeen = 1'b0; // Release of a key, history kept
			else begin
				modelPrev = modelNow;
				modelNow = code;
			end
		end
	endtask

	task automatic readPort(input byteT addr, input byteT expected, input string what);
		@(posedge clk);
		portId <= addr;
		readRequest <= 1'b1;
		@(posedge clk);
		readRequest <= 1'b0;
		@(negedge clk); // Key byte one cycle after the request
		checkValue(keyOut, expected, what);
	endtask

	task automatic checkReads();
		readPort(portKeyNow, modelNow, "keyNow read");
		readPort(portKeyPrev, modelPrev, "keyPrev read");
		readPort(byteT'($urandom) | 8'h04, modelPrev, "keyOut after unused read"); // Never 0 or 1
	endtask

	task automatic writePort(input byteT addr, input byteT value);
		@(posedge clk);
		portId <= addr;
		outPort <= value;
		writeStrobe <= 1'b1;
		@(posedge clk);
		writeStrobe <= 1'b0;
		if (addr == portColorLow)
			modelFg[7:0] = value;
		else if (addr == portColorHigh)
			modelFg[11:8] = value[3:0];
	endtask

	// Cell rule, MSB in the leftmost cell
	function automatic rgbT expectColor(input int x, input int y);
		byteT k;
		if (x >= 8 * cellWidth || y >= 2 * bandHeight)
			return '0;
		k = (y < bandHeight) ? modelNow : modelPrev;
		if (!k[7 - x / cellWidth])
			return '0;
		return alarm ? alarmColor : modelFg;
	endfunction

	task automatic checkLines(input int frameNo, input int firstLine, input int lastLine);
		int pix, x, y, target;
		for (pix = firstLine * hTotal; pix < (lastLine + 1) * hTotal; pix++) begin
			target = frameNo * frameClocks + pixelDivide * pix + 2; // Mid-pixel
			while (relClk < target)
				@(negedge clk);
			x = pix % hTotal;
			y = pix / hTotal;
			checkValue(rgb, expectColor(x, y), "rgb");
			checkValue(hs, (x < 656) || (x > 751), "hs"); // Low in columns 656 to 751
			checkValue(vs, 1'b1, "vs");
		end
	endtask

	task automatic waitSpeakerEdge(output int at);
		logic last;
		int waited;
		last = speaker;
		waited = 0;
		@(negedge clk);
		while (speaker === last && waited < 2 * toneHalfA) begin
			@(negedge clk);
			waited++;
		end
		assert (speaker !== last) else begin
			errorCount++;
			$display("speaker stopped toggling while alarm was high");
		end
		at = relClk;
	endtask

	initial begin
		int unsigned rnd;
		int seed, i, lastClk, edgeClk, gap;
		byteT code;
		seed = 32'h88f2d961;
		rnd = $urandom(seed); // Seeds the generator
		reset = 1'b1;
		portId = '0;
		outPort = '0;
		writeStrobe = 1'b0;
		readRequest = 1'b0;
		alarm = 1'b0;
		ps2c = 1'b1; // PS/2 bus idles high
		ps2d = 1'b1;
		repeat (3) @(posedge clk);
		@(negedge clk);
		checkValue(keyOut, 0, "keyOut after reset");
		checkValue(rgb, 0, "rgb after reset");
		checkValue(speaker, 0, "speaker after reset");
		checkValue({hs, vs}, 2'b11, "syncs after reset");
		@(posedge clk);
		reset <= 1'b0;

		for (i = 0; i < 20; i++) begin
			code = byteT'($urandom);
			if (code == breakPrefix)
				code = 8'h1C;
			sendFrame(code, 1'b0, 1'b0);
			if ($urandom % 2) begin
				sendFrame(breakPrefix, 1'b0, 1'b0);
				sendFrame(code, 1'b0, 1'b0);
			end
			checkReads();
		end

		rnd = $urandom % 2; // Parity or stop bit
		sendFrame(byteT'($urandom) & 8'h7F, rnd == 0, rnd == 1);
		checkReads();

		// Siren in the gap before frame 1
		@(posedge clk);
		alarm <= 1'b1;
		@(negedge clk);
		lastClk = relClk;
		for (i = 1; i <= toneSegment + 3; i++) begin // Odd edge count leaves speaker high
			waitSpeakerEdge(edgeClk);
			gap = (((i - 1) / toneSegment) % 2) ? toneHalfB : toneHalfA;
			checkValue(edgeClk - lastClk, gap, "speaker edge spacing");
			lastClk = edgeClk;
		end
		@(posedge clk);
		alarm <= 1'b0;
		repeat (2) @(negedge clk);
		while (relClk < frameClocks - 4000) begin
			checkValue(speaker, 0, "speaker after alarm");
			@(negedge clk);
		end

		for (i = 0; i < 6; i++)
			writePort(portColorLow + byteT'($urandom % 3), byteT'($urandom)); // 8'h04 ignored
		checkLines(1, 0, bandHeight - 1);
		@(posedge clk); // Blanking of line 15
		alarm <= 1'b1;
		checkLines(1, bandHeight, 2 * bandHeight - 1);
		@(posedge clk);
		alarm <= 1'b0;

		$display("checks %0d, errors %0d", checkCount, errorCount);
		if (errorCount == 0)
			$display("TEST RESULT: PASS");
		else
			$display("TEST RESULT: FAIL");
		$finish;
	end

endmodule

`default_nettype wire

/* alarmConsole.sv */
// Alarm console top level
`timescale 1ns/1ps
`default_nettype none

module alarmConsole import consolePkg::*; (
	input logic clk,
	input logic reset,
	input byteT portId,
	input logic writeStrobe,
	input byteT outPort,
	input logic readRequest,
	output byteT keyOut,
	input logic alarm,
	input logic ps2c,
	input logic ps2d,
	output rgbT rgb,
	output logic hs,
	output logic vs,
	output logic speaker
);

	logic pixelEnable;
	hCountT hCount;
	vCountT vCount;
	logic hSyncNext;
	logic vSyncNext;
	logic visibleNext;

	keyBus keys(); // Keyboard to display

	ps2Receiver keyboard (
		.clk(clk), .reset(reset),
		.ps2c(ps2c), .ps2d(ps2d),
		.portId(portId), .readRequest(readRequest), .keyOut(keyOut),
		.keys(keys.source)
	);

	vgaTiming timing (
		.clk(clk), .reset(reset),
		.pixelEnable(pixelEnable), .hCount(hCount), .vCount(vCount),
		.hSyncNext(hSyncNext), .vSyncNext(vSyncNext), .visibleNext(visibleNext)
	);

	vgaRenderer renderer (
		.clk(clk), .reset(reset),
		.pixelEnable(pixelEnable), .hCount(hCount), .vCount(vCount),
		.hSyncNext(hSyncNext), .vSyncNext(vSyncNext), .visibleNext(visibleNext),
		.portId(portId), .writeStrobe(writeStrobe), .outPort(outPort),
		.alarm(alarm), .keys(keys.sink),
		.rgb(rgb), .hs(hs), .vs(vs)
	);

	alarmTone tone (
		.clk(clk), .reset(reset),
		.alarm(alarm), .speaker(speaker)
	);

endmodule

`default_nettype wire

/* alarmTone.sv */
// Two-tone alarm siren
`timescale 1ns/1ps
`default_nettype none

module alarmTone import consolePkg::*; (
	input logic clk,
	input logic reset,
	input logic alarm,
	output logic speaker
);

	toneCountT halfCount; // Clocks into this half period
	toneCountT halfLimit; // Last count of the current tone
	logic [$clog2(toneSegment)-1:0] edgeCount; // Edges in this segment
	logic toneSel; // Low for tone A, high for tone B

	assign halfLimit = (toneSel ? toneHalfB : toneHalfA) - toneCountT'(1);

	// Alarm acts as the clock enable and clears everything when low
	always_ff @(posedge clk) begin
		if (reset || !alarm) begin
			halfCount <= '0;
			edgeCount <= '0;
			toneSel <= 1'b0;
			speaker <= 1'b0;
		end else if (halfCount == halfLimit) begin
			halfCount <= '0;
			speaker <= !speaker;
			if (edgeCount == toneSegment - 1) begin
				edgeCount <= '0;
				toneSel <= !toneSel; // Swap tone after a full segment
			end else begin
				edgeCount <= edgeCount + 1'b1;
			end
		end else begin
			halfCount <= halfCount + toneCountT'(1);
		end
	end

endmodule

`default_nettype wire

/* vgaRenderer.sv */
// VGA key cell renderer
`timescale 1ns/1ps
`default_nettype none

module vgaRenderer import consolePkg::*; (
	input logic clk,
	input logic reset,
	input logic pixelEnable,
	input hCountT hCount,
	input vCountT vCount,
	input logic hSyncNext,
	input logic vSyncNext,
	input logic visibleNext,
	input byteT portId,
	input logic writeStrobe,
	input byteT outPort,
	input logic alarm,
	keyBus.sink keys,
	output rgbT rgb,
	output logic hs,
	output logic vs
);

	rgbT foreground; // Processor written colour
	rgbT cellColor; // Colour of a lit cell
	byteT keySel; // Key shown in this band
	logic [2:0] cellIndex; // Cell number across the row
	logic inRows; // Inside the two key bands
	logic inCells; // Inside the eight cells
	logic lit;

	// Foreground colour from the port bus
	always_ff @(posedge clk) begin
		if (reset)
			foreground <= resetColor;
		else if (writeStrobe && portId == portColorLow)
			foreground[7:0] <= outPort; // Green and blue
		else if (writeStrobe && portId == portColorHigh)
			foreground[11:8] <= outPort[3:0]; // Red
	end

	// Band and cell lookup
	always_comb begin
		keySel = (vCount < vCountT'(bandHeight)) ? keys.keyNow : keys.keyPrev;
		inRows = vCount < vCountT'(2 * bandHeight);
		inCells = hCount < hCountT'(8 * cellWidth);
		cellIndex = 3'(hCount / cellWidth);
		lit = visibleNext && inRows && inCells && keySel[3'd7 - cellIndex]; // MSB leftmost
		cellColor = alarm ? alarmColor : foreground;
	end

	// Colour and sync leave together
	always_ff @(posedge clk) begin
		if (reset) begin
			rgb <= '0;
			hs <= 1'b1;
			vs <= 1'b1;
		end else if (pixelEnable) begin
			rgb <= lit ? cellColor : rgbT'(0);
			hs <= hSyncNext;
			vs <= vSyncNext;
		end
	end

endmodule

`default_nettype wire

/* vgaTiming.sv */
// VGA timing generator
`timescale 1ns/1ps
`default_nettype none

module vgaTiming import consolePkg::*; (
	input logic clk,
	input logic reset,
	output logic pixelEnable,
	output hCountT hCount,
	output vCountT vCount,
	output logic hSyncNext,
	output logic vSyncNext,
	output logic visibleNext
);

	logic [$clog2(pixelDivide)-1:0] divCount; // Clock phase within a pixel
	logic lineEnd; // Last column of the line
	logic frameEnd; // Last line of the frame

	assign pixelEnable = (divCount == '0); // First clock after reset is a pixel
	assign lineEnd = (hCount == hTotal - 10'd1);
	assign frameEnd = (vCount == vTotal - 10'd1);

	always_ff @(posedge clk) begin
		if (reset)
			divCount <= '0;
		else if (divCount == pixelDivide - 1)
			divCount <= '0;
		else
			divCount <= divCount + 1'b1;
	end

	// Column and line counters
	always_ff @(posedge clk) begin
		if (reset) begin
			hCount <= '0;
			vCount <= '0;
		end else if (pixelEnable) begin
			if (lineEnd) begin
				hCount <= '0;
				if (frameEnd)
					vCount <= '0;
				else
					vCount <= vCount + 10'd1;
			end else begin
				hCount <= hCount + 10'd1;
			end
		end
	end

	// Decoded for the current counters, registered by the renderer
	assign hSyncNext = !(hCount >= hSyncStart && hCount < hSyncEnd); // Active low
	assign vSyncNext = !(vCount >= vSyncStart && vCount < vSyncEnd); // Active low
	assign visibleNext = (hCount < hVisible) && (vCount < vVisible);

endmodule

`default_nettype wire

/* ps2Receiver.sv */
// PS/2 keyboard receiver
`timescale 1ns/1ps
`default_nettype none

module ps2Receiver import consolePkg::*; (
	input logic clk,
	input logic reset,
	input logic ps2c,
	input logic ps2d,
	input byteT portId,
	input logic readRequest,
	output byteT keyOut,
	keyBus.source keys
);

	typedef enum logic [1:0] {idle, data, parity, stop} ps2StateT;

	ps2StateT state;
	logic [filterDepth-1:0] ps2cShift; // Recent keyboard clock samples
	logic ps2dReg; // Sampled keyboard data
	logic cleanClk; // Filtered keyboard clock level
	logic fallEdge; // Filtered falling edge
	logic [2:0] bitCount; // Data bit index
	byteT dataShift; // LSB first shift register
	logic parityBit;
	logic frameValid; // Good frame, one clock
	logic breakPending; // Last code was the break prefix

	assign fallEdge = cleanClk && (ps2cShift == '0); // Stable low after stable high

	always_ff @(posedge clk) begin
		ps2cShift <= {ps2cShift[filterDepth-2:0], ps2c};
		ps2dReg <= ps2d;
		if (reset)
			cleanClk <= 1'b1; // Idle bus is high
		else if (ps2cShift == '1)
			cleanClk <= 1'b1;
		else if (ps2cShift == '0)
			cleanClk <= 1'b0;
	end

	// Frame FSM, one step per filtered falling edge
	always_ff @(posedge clk) begin
		if (reset) begin
			state <= idle;
			bitCount <= '0;
			frameValid <= 1'b0;
		end else begin
			frameValid <= 1'b0; // Pulse by default
			if (fallEdge) begin
				case (state)
					idle: begin
						bitCount <= '0;
						if (!ps2dReg)
							state <= data; // Start bit
					end
					data: begin
						bitCount <= bitCount + 3'd1;
						if (bitCount == 3'd7)
							state <= parity;
					end
					parity: state <= stop;
					stop: begin
						frameValid <= ps2dReg && (^{dataShift, parityBit}); // Stop and odd parity
						state <= idle;
					end
					default: state <= idle;
				endcase
			end
		end
	end

	always_ff @(posedge clk) begin
		if (fallEdge && state == data)
			dataShift <= {ps2dReg, dataShift[7:1]}; // LSB arrives first
		if (fallEdge && state == parity)
			parityBit <= ps2dReg;
	end

	// Key history and release tracking
	always_ff @(posedge clk) begin
		if (reset) begin
			keys.keyNow <= '0;
			keys.keyPrev <= '0;
			keys.keyNew <= 1'b0;
			keys.keyReleased <= 1'b0;
			breakPending <= 1'b0;
		end else begin
			keys.keyNew <= 1'b0;
			if (frameValid) begin
				if (dataShift == breakPrefix)
					breakPending <= 1'b1;
				else if (breakPending) begin
					breakPending <= 1'b0; // Released code is not stored
					keys.keyReleased <= 1'b1;
				end else begin
					keys.keyPrev <= keys.keyNow;
					keys.keyNow <= dataShift;
					keys.keyNew <= 1'b1;
					keys.keyReleased <= 1'b0;
				end
			end
		end
	end

	// Processor read port
	always_ff @(posedge clk) begin
		if (reset)
			keyOut <= '0;
		else if (readRequest && portId == portKeyNow)
			keyOut <= keys.keyNow;
		else if (readRequest && portId == portKeyPrev)
			keyOut <= keys.keyPrev;
	end

endmodule

`default_nettype wire

/* keyBus.sv */
// Key code bus
`timescale 1ns/1ps
`default_nettype none

interface keyBus import consolePkg::*; ();

	byteT keyNow; // Latest make code
	byteT keyPrev; // Make code before keyNow
	logic keyNew; // One clock on each new make code
	logic keyReleased; // Break seen for keyNow

	modport source (
		output keyNow, keyPrev, keyNew, keyReleased
	);

	modport sink (
		input keyNow, keyPrev, keyNew, keyReleased
	);

endinterface

`default_nettype wire

/* consolePkg.sv */
// Console shared definitions
`default_nettype none

package consolePkg;

	typedef logic [7:0] byteT; // Port data, port addresses, scan codes
	typedef logic [11:0] rgbT; // Red, green, blue nibbles
	typedef logic [9:0] hCountT; // Pixel column
	typedef logic [9:0] vCountT; // Pixel line
	typedef logic [16:0] toneCountT; // Holds the longest tone half period

	localparam byteT portKeyNow = 8'h00; // Read current key
	localparam byteT portKeyPrev = 8'h01; // Read previous key
	localparam byteT portColorLow = 8'h02; // Green and blue write
	localparam byteT portColorHigh = 8'h03; // Red write, low nibble
	localparam byteT breakPrefix = 8'hF0; // Key release marker

	localparam int pixelDivide = 4; // Clocks per pixel
	localparam hCountT hVisible = 10'd640;
	localparam hCountT hSyncStart = 10'd656;
	localparam hCountT hSyncEnd = 10'd752;
	localparam hCountT hTotal = 10'd800;
	localparam vCountT vVisible = 10'd480;
	localparam vCountT vSyncStart = 10'd490;
	localparam vCountT vSyncEnd = 10'd492;
	localparam vCountT vTotal = 10'd525;
	localparam int cellWidth = 32; // Pixels per bit cell
	localparam int bandHeight = 16; // Lines per key row

	localparam rgbT alarmColor = 12'hF00; // Red under alarm
	localparam rgbT resetColor = 12'hFFF; // White foreground

	localparam toneCountT toneHalfA = 17'd113636; // First tone half period
	localparam toneCountT toneHalfB = 17'd90909; // Second tone half period
	localparam int toneSegment = 8; // Speaker edges per tone
	localparam int filterDepth = 4; // Stable ps2c samples per level

endpackage

`default_nettype wire
